// File: Makefile
# Verilator build for the UDP receive path testbench

VERILATOR := verilator
TOP       := tb_udp_rx
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+verilog
verilog/net_pkg.sv
verilog/buf_pkg.sv
verilog/udp_rx.sv
verilog/buf_arbiter.sv
verilog/payload_ram.sv
verilog/udp_rx_top.sv
testbench/tb_udp_rx.sv

// File: testbench/tb_udp_rx.sv
////////////////////////////////////////////////////////////
// testbench for the UDP receive path top level
// random datagrams from an LFSR checked against a local model
// compiled together with the RTL through the file list
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "udp_macros.svh"

module tb_udp_rx
  import net_pkg::*;
  import buf_pkg::*;
();

  localparam int AW      = `UDP_BUF_AW;
  localparam int NUM_PKT = 21;
  // payload stays well inside the RAM depth
  localparam int MAX_PAY = 511;
  localparam int MAX_LEN = MAX_PAY + 8;
  // receive plus read-back per packet
  localparam int CYCLE_LIMIT = NUM_PKT * (2 * MAX_LEN + 100);

  logic              clk;
  logic              rst_n;
  logic              meta_valid;
  logic              meta_ready;
  ip_meta_t          meta;
  logic              rx_valid;
  logic [7:0]        rx_data;
  logic              rx_abort;
  logic              res_valid;
  logic              res_ready;
  udp_result_t       res;
  logic              rd_valid;
  logic              rd_ready;
  logic [AW-1:0]     rd_addr;
  logic              rd_rsp_valid;
  mem_rsp_t          rd_rsp;

  // model state
  logic [31:0]       lfsr_q = 32'h14541cbe;
  logic [7:0]        dg [0:MAX_LEN-1];
  logic [7:0]        mem_model [0:`UDP_BUF_DEPTH-1];
  int                filled;
  int                cycles;
  string             test_name;
  logic              rand_rd;
  logic              pend_valid;
  logic [AW-1:0]     pend_addr;
  logic [7:0]        pend_data;
  logic              wr_busy;
  logic              rsp_due;
  logic [7:0]        rsp_exp;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  udp_rx_top i_udp_rx_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .meta_valid   (meta_valid),
    .meta_ready   (meta_ready),
    .meta         (meta),
    .rx_valid     (rx_valid),
    .rx_data      (rx_data),
    .rx_abort     (rx_abort),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res          (res),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .rd_addr      (rd_addr),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp       (rd_rsp)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp)
      stop_run($sformatf("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act));
  endtask

  // fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // one's-complement sum of pseudo-header and the first n datagram bytes
  function automatic logic [15:0] ones_sum(input ip_meta_t m, input int n);
    logic [31:0] acc;
    int          i;
    acc = 32'(m.src_ip[31:16]) + 32'(m.src_ip[15:0]) + 32'(m.dst_ip[31:16])
        + 32'(m.dst_ip[15:0]) + 32'(m.protocol) + 32'(m.udp_len);
    for (i = 0; i < n; i = i + 2)
    begin
      if (i + 1 < n)
        acc = acc + 32'({dg[i], dg[i + 1]});
      else
        acc = acc + 32'({dg[i], 8'h00});
    end
    while (acc[31:16] != 16'd0)
      acc = 32'(acc[15:0]) + 32'(acc[31:16]);
    return acc[15:0];
  endfunction

  // a read is granted only in a cycle without a payload write
  task automatic issue_read(input logic [AW-1:0] addr, input logic [7:0] exp);
    rd_valid = 1'b1;
    rd_addr  = addr;
    rsp_due  = !wr_busy;
    rsp_exp  = exp;
  endtask

  // one clock with an optional random host read and the read response check
  task automatic tick;
    logic [AW-1:0] a;
    if (rand_rd && filled > 0 && rand_bits(2) == 0)
    begin
      a = AW'(rand_bits(11) % 32'(filled));
      issue_read(a, mem_model[a]);
    end
    @(posedge clk);
    #1;
    cycles++;
    if (cycles > CYCLE_LIMIT)
      stop_run($sformatf("timeout: run exceeded %0d clock cycles", CYCLE_LIMIT));
    check("rd_rsp_valid", 64'(rsp_due), 64'(rd_rsp_valid));
    if (rsp_due)
      check("rd_rsp", 64'(rsp_exp), 64'(rd_rsp.rdata));
    rsp_due  = 1'b0;
    rd_valid = 1'b0;
    // byte sampled at this edge lands in the RAM on the next one
    wr_busy = pend_valid;
    check("rd_ready", 64'(!wr_busy), 64'(rd_ready));
    if (pend_valid)
    begin
      mem_model[pend_addr] = pend_data;
      if (int'(pend_addr) >= filled)
        filled = int'(pend_addr) + 1;
      pend_valid = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one datagram of kind 0 good, 1 corrupt, 2 no checksum, 3 length, 4 abort
  ////////////////////////////////////////////////////////////
  task automatic run_dgram(input int kind);
    ip_meta_t     m;
    logic [15:0]  ulen;
    logic [15:0]  csum;
    udp_status_t  exp_st;
    udp_result_t  held;
    int           abort_at;
    int           idx;
    int           t_last;
    logic         got;
    logic         taken;
    ulen       = 16'(rand_bits(9)) + 16'd8;
    m.src_ip   = rand_bits(32);
    m.dst_ip   = rand_bits(32);
    m.protocol = 8'd17;
    m.udp_len  = ulen;
    for (idx = 0; idx < int'(ulen); idx++)
      dg[idx] = 8'(rand_bits(8));
    if (kind == 3)
      {dg[4], dg[5]} = ulen ^ (16'd1 << rand_bits(4));
    else
      {dg[4], dg[5]} = ulen;
    {dg[6], dg[7]} = 16'h0000;
    // a computed zero goes out as all ones
    csum = ~ones_sum(m, int'(ulen));
    if (csum == 16'h0000)
      csum = 16'hffff;
    if (kind != 2)
      {dg[6], dg[7]} = csum;
    if (kind == 1)
    begin
      // flip one bit outside the length and checksum fields
      idx = int'(rand_bits(16)) % int'(ulen);
      if (idx >= 4 && idx < 8)
        idx = idx - 4;
      dg[idx] = dg[idx] ^ (8'd1 << rand_bits(3));
    end
    abort_at = (kind == 4) ? 1 + int'(rand_bits(16)) % (int'(ulen) - 1) : -1;
    case (kind)
      1:       exp_st = status_csum_bad;
      3:       exp_st = status_len_bad;
      4:       exp_st = status_aborted;
      default: exp_st = status_ok;
    endcase

    while (!meta_ready)
      tick();
    meta_valid = 1'b1;
    meta       = m;
    tick();
    meta_valid = 1'b0;

    // byte stream with random gaps
    for (idx = 0; idx < int'(ulen); idx++)
    begin
      while (rand_bits(3) == 0)
      begin
        rx_valid = 1'b0;
        tick();
      end
      if (idx == abort_at)
      begin
        rx_valid = 1'b0;
        rx_abort = 1'b1;
        tick();
        rx_abort = 1'b0;
        break;
      end
      rx_valid = 1'b1;
      rx_data  = dg[idx];
      if (idx >= 8)
      begin
        pend_valid = 1'b1;
        pend_addr  = AW'(idx - 8);
        pend_data  = dg[idx];
      end
      tick();
    end
    rx_valid = 1'b0;
    t_last   = cycles;

    // result under random res_ready stalls
    got   = 1'b0;
    taken = 1'b0;
    while (!taken)
    begin
      if (res_valid)
      begin
        if (!got)
        begin
          got  = 1'b1;
          held = res;
          check("latency", (kind == 4) ? 64'd0 : 64'(`UDP_RESULT_LAT), 64'(cycles - t_last));
          check("status", 64'(exp_st), 64'(res.status));
          check("payload_len", (kind == 4) ? 64'd0 : 64'(ulen - 16'd8),
                64'(res.payload_len));
          if (kind != 4)
          begin
            check("src_port", 64'({dg[0], dg[1]}), 64'(res.src_port));
            check("dst_port", 64'({dg[2], dg[3]}), 64'(res.dst_port));
          end
        end
        check("res_held", 64'(held), 64'(res));
        res_ready = (rand_bits(2) == 0);
        taken     = res_ready;
      end
      check("meta_ready_busy", 64'd0, 64'(meta_ready));
      tick();
    end
    res_ready = 1'b0;
    check("res_valid_after", 64'd0, 64'(res_valid));
    check("meta_ready_after", 64'd1, 64'(meta_ready));

    // pipelined read-back of the whole payload
    if (kind == 0)
    begin
      rand_rd = 1'b0;
      idx     = 0;
      while (idx < int'(ulen) - 8)
      begin
        issue_read(AW'(idx), dg[idx + 8]);
        if (rsp_due)
          idx++;
        tick();
      end
      rand_rd = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int pkt;
    rst_n      = 1'b0;
    meta_valid = 1'b0;
    meta       = '0;
    rx_valid   = 1'b0;
    rx_data    = 8'h00;
    rx_abort   = 1'b0;
    res_ready  = 1'b0;
    rd_valid   = 1'b0;
    rd_addr    = '0;
    rand_rd    = 1'b0;
    pend_valid = 1'b0;
    wr_busy    = 1'b0;
    rsp_due    = 1'b0;
    filled     = 0;
    cycles     = 0;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check("meta_ready", 64'd1, 64'(meta_ready));
    check("res_valid", 64'd0, 64'(res_valid));
    check("rd_rsp_valid", 64'd0, 64'(rd_rsp_valid));
    check("rd_ready", 64'd1, 64'(rd_ready));
    rand_rd = 1'b1;
    // every abort is followed by a good datagram
    for (pkt = 0; pkt < NUM_PKT; pkt++)
    begin
      case (pkt % 5)
        0:       test_name = "good";
        1:       test_name = "csum_bad";
        2:       test_name = "zero_csum";
        3:       test_name = "len_bad";
        default: test_name = "abort";
      endcase
      run_dgram(pkt % 5);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/buf_arbiter.sv
////////////////////////////////////////////////////////////
// fixed-priority owner of the single payload RAM port
// receiver writes always win and host reads fill the gaps
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "udp_macros.svh"

module buf_arbiter
  import buf_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   wr_valid,
  input  wire mem_req_t               wr_req,
  input  wire logic                   rd_valid,
  output logic                        rd_ready,
  input  wire logic [`UDP_BUF_AW-1:0] rd_addr,
  output logic                        rd_rsp_valid,
  output mem_rsp_t                    rd_rsp,
  output logic                        ram_en,
  output mem_req_t                    ram_req,
  input  wire mem_rsp_t               ram_rsp
);

  logic rd_grant;

  // the byte stream cannot stall, so reads back off
  assign rd_ready = !wr_valid;
  assign rd_grant = rd_valid && !wr_valid;

  ////////////////////////////////////////////////////////////
  // port select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (wr_valid)
    begin
      ram_en  = 1'b1;
      ram_req = wr_req;
    end
    else
    begin
      ram_en        = rd_valid;
      ram_req.write = 1'b0;
      ram_req.addr  = rd_addr;
      ram_req.wdata = 8'h00;
    end
  end

  // RAM data returns one cycle after a granted read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_rsp_valid <= 1'b0;
    else
      rd_rsp_valid <= rd_grant;
  end

  assign rd_rsp = ram_rsp;

endmodule

`default_nettype wire

// File: verilog/buf_pkg.sv
////////////////////////////////////////////////////////////
// payload buffer access types
// shared by receiver, arbiter, RAM and top level
////////////////////////////////////////////////////////////
`default_nettype none

`include "udp_macros.svh"

package buf_pkg;

  // one RAM port request, write or read
  typedef struct packed {
    logic                   write;
    logic [`UDP_BUF_AW-1:0] addr;
    logic [7:0]             wdata;
  } mem_req_t;

  // registered read data
  typedef struct packed {
    logic [7:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/net_pkg.sv
////////////////////////////////////////////////////////////
// network-facing types of the UDP receiver
// IP metadata in, result record and status codes out
////////////////////////////////////////////////////////////
`default_nettype none

package net_pkg;

  // facts already parsed by the IP layer
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [7:0]  protocol;
    // header plus payload
    logic [15:0] udp_len;
  } ip_meta_t;

  typedef enum logic [1:0] {
    status_ok       = 2'd0,
    status_csum_bad = 2'd1,
    // header length differs from meta, or meta length below 8
    status_len_bad  = 2'd2,
    status_aborted  = 2'd3
  } udp_status_t;

  // one record per datagram
  typedef struct packed {
    udp_status_t status;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] payload_len;
  } udp_result_t;

endpackage

`default_nettype wire

// File: verilog/payload_ram.sv
////////////////////////////////////////////////////////////
// single-port byte RAM for one datagram payload
// writes store on enable and reads return on the next cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "udp_macros.svh"

module payload_ram
  import buf_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     ram_en,
  input  wire mem_req_t ram_req,
  output mem_rsp_t      ram_rsp
);

  logic [7:0] mem [0:`UDP_BUF_DEPTH-1];
  logic [7:0] rdata_q;

  always_ff @(posedge clk)
  begin
    if (ram_en)
    begin
      if (ram_req.write)
        mem[ram_req.addr] <= ram_req.wdata;
      else
        rdata_q <= mem[ram_req.addr];
    end
  end

  // output holds the last read across write cycles
  assign ram_rsp = '{rdata: rdata_q};

endmodule

`default_nettype wire

// File: verilog/udp_macros.svh
////////////////////////////////////////////////////////////
// build-time sizes for the UDP receive path
// included by the buffer package and every RTL module
////////////////////////////////////////////////////////////
`ifndef UDP_MACROS_SVH
`define UDP_MACROS_SVH

// payload RAM depth in bytes for one datagram
`define UDP_BUF_DEPTH 2048

// address width matching the depth above
`define UDP_BUF_AW 11

// cycles from last accepted byte to res_valid
// the fold pipeline needs at least 4
`define UDP_RESULT_LAT 4

`endif

// File: verilog/udp_rx.sv
////////////////////////////////////////////////////////////
// UDP datagram receiver with length check, checksum and payload write
// takes IP metadata per datagram, then one byte per valid beat
// returns one result record and holds it until res_ready
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "udp_macros.svh"

module udp_rx
  import net_pkg::*;
  import buf_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        meta_valid,
  output logic             meta_ready,
  input  wire ip_meta_t    meta,
  input  wire logic        rx_valid,
  input  wire logic        rx_abort,
  input  wire logic [7:0]  rx_data,
  output logic             wr_valid,
  output mem_req_t         wr_req,
  output logic             res_valid,
  input  wire logic        res_ready,
  output udp_result_t      res
);

  typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_data,
    st_verify,
    st_result
  } rx_state_t;

  rx_state_t   state;
  logic [15:0] byte_cnt;
  logic [3:0]  lat_cnt;
  logic [15:0] last_idx;
  logic [15:0] pay_len;
  logic [15:0] udp_len_q;
  logic [7:0]  byte_q;
  logic [15:0] src_port_q;
  logic [15:0] dst_port_q;
  logic [15:0] hdr_len_q;
  logic [15:0] csum_field_q;
  logic [`UDP_BUF_AW-1:0] wr_addr_q;
  logic [31:0] csum_acc;
  logic [16:0] fold1_q;
  logic [15:0] fold2_q;
  logic [15:0] csum_q;
  udp_result_t res_q;

  logic        open;
  logic        beat;
  logic        len_bad;
  logic        verify_done;
  logic [15:0] pair;
  logic [15:0] pay_idx;
  logic [31:0] pseudo_sum;

  assign open        = (state == st_header) || (state == st_data);
  assign beat        = open && rx_valid && !rx_abort;
  assign pair        = {byte_q, rx_data};
  assign pay_idx     = byte_cnt - 16'd8;
  assign len_bad     = (hdr_len_q != udp_len_q) || (udp_len_q < 16'd8);
  assign verify_done = (state == st_verify) && (lat_cnt == 4'(`UDP_RESULT_LAT - 1));

  // pseudo-header words, summed once at meta acceptance
  assign pseudo_sum = 32'(meta.src_ip[31:16]) + 32'(meta.src_ip[15:0])
                    + 32'(meta.dst_ip[31:16]) + 32'(meta.dst_ip[15:0])
                    + 32'(meta.protocol) + 32'(meta.udp_len);

  ////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      byte_cnt <= 16'd0;
      lat_cnt  <= 4'd0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          byte_cnt <= 16'd0;
          if (meta_valid)
            state <= st_header;
        end
        st_header, st_data:
        begin
          if (rx_abort)
            state <= st_result;
          else if (rx_valid)
          begin
            byte_cnt <= byte_cnt + 16'd1;
            if (byte_cnt == last_idx)
            begin
              state   <= st_verify;
              lat_cnt <= 4'd0;
            end
            else if (byte_cnt == 16'd7)
              state <= st_data;
          end
        end
        st_verify:
        begin
          lat_cnt <= lat_cnt + 4'd1;
          if (verify_done)
            state <= st_result;
        end
        st_result:
        begin
          if (res_ready)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // per-datagram lengths
  // a short meta length still waits for 8 header bytes
  always_ff @(posedge clk)
  begin
    if (meta_valid && meta_ready)
    begin
      udp_len_q <= meta.udp_len;
      last_idx  <= (meta.udp_len < 16'd8) ? 16'd7 : meta.udp_len - 16'd1;
      pay_len   <= (meta.udp_len < 16'd8) ? 16'd0 : meta.udp_len - 16'd8;
    end
  end

  ////////////////////////////////////////////////////////////
  // byte capture and header fields
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (beat)
    begin
      byte_q    <= rx_data;
      wr_addr_q <= pay_idx[`UDP_BUF_AW-1:0];
      case (byte_cnt)
        16'd1:   src_port_q   <= pair;
        16'd3:   dst_port_q   <= pair;
        16'd5:   hdr_len_q    <= pair;
        16'd7:   csum_field_q <= pair;
        default: ;
      endcase
    end
  end

  // write request one cycle after the payload beat
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_valid <= 1'b0;
    else
      wr_valid <= beat && (state == st_data) && (pay_idx < 16'(`UDP_BUF_DEPTH));
  end

  assign wr_req = '{write: 1'b1, addr: wr_addr_q, wdata: byte_q};

  ////////////////////////////////////////////////////////////
  // one's-complement sum and fold pipeline
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (meta_valid && meta_ready)
      csum_acc <= pseudo_sum;
    else if (beat)
    begin
      // big-endian pairs with an odd last byte padded with zero
      if (byte_cnt[0])
        csum_acc <= csum_acc + 32'(pair);
      else if (byte_cnt == last_idx)
        csum_acc <= csum_acc + 32'({rx_data, 8'h00});
    end
  end

  // two folds cover any accumulator value, then invert
  always_ff @(posedge clk)
  begin
    fold1_q <= {1'b0, csum_acc[15:0]} + {1'b0, csum_acc[31:16]};
    fold2_q <= fold1_q[15:0] + {15'd0, fold1_q[16]};
    csum_q  <= ~fold2_q;
  end

  ////////////////////////////////////////////////////////////
  // result record
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (verify_done)
    begin
      res_q.src_port    <= src_port_q;
      res_q.dst_port    <= dst_port_q;
      res_q.payload_len <= pay_len;
      if (len_bad)
        res_q.status <= status_len_bad;
      else if ((csum_field_q == 16'd0) || (csum_q == 16'd0))
        res_q.status <= status_ok;
      else
        res_q.status <= status_csum_bad;
    end
    else if (open && rx_abort)
    begin
      res_q.status      <= status_aborted;
      res_q.src_port    <= src_port_q;
      res_q.dst_port    <= dst_port_q;
      res_q.payload_len <= 16'd0;
    end
  end

  assign meta_ready = (state == st_idle);
  assign res_valid  = (state == st_result);
  assign res        = res_q;

endmodule

`default_nettype wire

// File: verilog/udp_rx_top.sv
////////////////////////////////////////////////////////////
// UDP receive path top level
// receiver and host share the payload RAM through the arbiter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "udp_macros.svh"

module udp_rx_top
  import net_pkg::*;
  import buf_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   meta_valid,
  output logic                        meta_ready,
  input  wire ip_meta_t               meta,
  input  wire logic                   rx_valid,
  input  wire logic [7:0]             rx_data,
  input  wire logic                   rx_abort,
  output logic                        res_valid,
  input  wire logic                   res_ready,
  output udp_result_t                 res,
  input  wire logic                   rd_valid,
  output logic                        rd_ready,
  input  wire logic [`UDP_BUF_AW-1:0] rd_addr,
  output logic                        rd_rsp_valid,
  output mem_rsp_t                    rd_rsp
);

  logic     wr_valid;
  mem_req_t wr_req;
  logic     ram_en;
  mem_req_t ram_req;
  mem_rsp_t ram_rsp;

  udp_rx i_udp_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .meta_valid (meta_valid),
    .meta_ready (meta_ready),
    .meta       (meta),
    .rx_valid   (rx_valid),
    .rx_abort   (rx_abort),
    .rx_data    (rx_data),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res        (res)
  );

  buf_arbiter i_buf_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_valid     (wr_valid),
    .wr_req       (wr_req),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .rd_addr      (rd_addr),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp       (rd_rsp),
    .ram_en       (ram_en),
    .ram_req      (ram_req),
    .ram_rsp      (ram_rsp)
  );

  payload_ram i_payload_ram (
    .clk     (clk),
    .ram_en  (ram_en),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

`default_nettype wire
